/* include/bdDecoder_defines.svh */
`ifndef BD_DECODER_DEFINES_SVH
`define BD_DECODER_DEFINES_SVH

// raw word from the BD output funnel
`define BD_DATA_W 34

// widest payload carried in a single word (roTat)
`define BD_SINGLE_PAYLOAD_W 32

// widest payload after chunk assembly (dumpAm)
`define BD_PAYLOAD_W 38

// one half of a dumpAm payload
`define BD_AM_CHUNK_W 19

// word FIFO entries, power of two
`define BD_FIFO_DEPTH 4

`endif

/* logic/bdRoutePkg.sv */
`default_nettype none

`include "bdDecoder_defines.svh"

package bdRoutePkg;

  // funnel leaves in table order
  // enum value doubles as the leaf code
  typedef enum logic [3:0] {
    dumpAm,
    dumpMm,
    dumpPat,
    dumpPostFifo0,
    dumpPostFifo1,
    dumpPreFifo,
    dumpTat0,
    dumpTat1,
    nrni,
    ovflw0,
    ovflw1,
    roAcc,
    roTat,
    invalid
  } leafT;

  localparam int NUM_LEAVES = 13;

  ////////////////////////////////////////////////////////////
  // route prefixes, left-aligned at the word msb
  // lower index wins when two routes hit
  localparam logic [`BD_DATA_W-1:0] ROUTE_VALUE [NUM_LEAVES] = '{
    {6'b101000,  28'd0},
    {6'b101001,  28'd0},
    {5'b10101,   29'd0},
    {6'b101110,  28'd0},
    {6'b101111,  28'd0},
    {6'b101101,  28'd0},
    {4'b1000,    30'd0},
    {4'b1001,    30'd0},
    {2'b11,      32'd0},
    {7'b1011000, 27'd0},
    {7'b1011001, 27'd0},
    {2'b01,      32'd0},
    {2'b00,      32'd0}
  };

  // one bit set per route bit, same order as above
  localparam logic [`BD_DATA_W-1:0] ROUTE_MASK [NUM_LEAVES] = '{
    {{6{1'b1}}, 28'd0},
    {{6{1'b1}}, 28'd0},
    {{5{1'b1}}, 29'd0},
    {{6{1'b1}}, 28'd0},
    {{6{1'b1}}, 28'd0},
    {{6{1'b1}}, 28'd0},
    {{4{1'b1}}, 30'd0},
    {{4{1'b1}}, 30'd0},
    {{2{1'b1}}, 32'd0},
    {{7{1'b1}}, 27'd0},
    {{7{1'b1}}, 27'd0},
    {{2{1'b1}}, 32'd0},
    {{2{1'b1}}, 32'd0}
  };

endpackage

`default_nettype wire

/* logic/bdStreamPkg.sv */
`default_nettype none

`include "bdDecoder_defines.svh"

package bdStreamPkg;

  ////////////////////////////////////////////////////////////
  // word formats on the links

  // raw BD output word: [ route | x | payload ]
  typedef struct packed {
    logic [`BD_DATA_W-1:0] data;
  } rawWordT;

  // decoded word, route stripped
  // payload zero-extended for single-chunk leaves
  typedef struct packed {
    bdRoutePkg::leafT          leaf;
    logic [`BD_PAYLOAD_W-1:0] payload;
  } decodedWordT;

  // AM chunk pairing
  typedef enum logic {
    waitLow,
    waitHigh
  } deserStateT;

endpackage

`default_nettype wire

/* logic/bdHornDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bdDecoder_defines.svh"

module bdHornDecoder (
  input  bdStreamPkg::rawWordT     inWord,
  input  logic                     inValid,
  output logic                     inReady,
  output bdStreamPkg::decodedWordT decWord,
  output logic                     decValid,
  input  logic                     decReady
);

  import bdRoutePkg::*;

  // one hit bit per route
  logic [NUM_LEAVES-1:0] hit;
  leafT                  leaf;
  // route bits of the winning leaf, zero for invalid
  logic [`BD_DATA_W-1:0] selMask;
  logic [`BD_DATA_W-1:0] strippedData;

  ////////////////////////////////////////////////////////////
  // prefix match, all routes at once

  for (genvar g = 0; g < NUM_LEAVES; g++) begin : gHit
    // keep only the route bits, then compare
    assign hit[g] = (inWord.data & ROUTE_MASK[g]) == ROUTE_VALUE[g];
  end

  ////////////////////////////////////////////////////////////
  // priority encode

  always_comb begin
    leaf    = invalid;
    selMask = '0;
    // walk downward so the lowest index is the last writer
    for (int i = NUM_LEAVES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        leaf    = leafT'(4'(i));
        selMask = ROUTE_MASK[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // payload

  // clear route bits
  // invalid keeps the raw word since selMask is zero
  assign strippedData = inWord.data & ~selMask;

  assign decWord.leaf    = leaf;
  // low 32 bits, zero-extended to the assembled width
  assign decWord.payload = {
    {(`BD_PAYLOAD_W - `BD_SINGLE_PAYLOAD_W){1'b0}},
    strippedData[`BD_SINGLE_PAYLOAD_W-1:0]
  };

  // no storage here, handshake passes straight through
  assign decValid = inValid;
  assign inReady  = decReady;

endmodule

`default_nettype wire

/* logic/bdWordFifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bdDecoder_defines.svh"

module bdWordFifo (
  input  logic                     clk,
  input  logic                     rstN,
  input  bdStreamPkg::decodedWordT inWord,
  input  logic                     inValid,
  output logic                     inReady,
  output bdStreamPkg::decodedWordT outWord,
  output logic                     outValid,
  input  logic                     outReady
);

  import bdStreamPkg::*;

  localparam int PTR_W = $clog2(`BD_FIFO_DEPTH);

  decodedWordT      mem [`BD_FIFO_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  // one extra bit so full and empty differ
  logic [PTR_W:0]   count;
  logic             full;
  logic             doWrite;
  logic             doRead;

  ////////////////////////////////////////////////////////////
  // status and handshake

  assign full     = count == (PTR_W + 1)'(`BD_FIFO_DEPTH);
  assign outValid = count != '0;
  // full but draining still takes a word
  assign inReady  = !full || outReady;

  assign doWrite = inValid && inReady;
  assign doRead  = outValid && outReady;

  // head of queue
  assign outWord = mem[rdPtr];

  ////////////////////////////////////////////////////////////
  // pointers and count

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      // pointers wrap on their own, depth is a power of two
      if (doWrite) wrPtr <= wrPtr + 1'b1;
      if (doRead) rdPtr <= rdPtr + 1'b1;
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (doWrite) mem[wrPtr] <= inWord;
  end

endmodule

`default_nettype wire

/* logic/bdAmDeserializer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bdDecoder_defines.svh"

module bdAmDeserializer (
  input  logic                     clk,
  input  logic                     rstN,
  input  bdStreamPkg::decodedWordT inWord,
  input  logic                     inValid,
  output logic                     inReady,
  output bdStreamPkg::decodedWordT outWord,
  output logic                     outValid,
  input  logic                     outReady
);

  import bdRoutePkg::*;
  import bdStreamPkg::*;

  // word taken from the FIFO, waiting for the output register
  decodedWordT               stageWord;
  logic                      stageValid;
  logic                      stageIsAm;
  // first dumpAm chunk
  deserStateT                state;
  logic [`BD_AM_CHUNK_W-1:0] lowChunk;
  // output register
  decodedWordT               outReg;
  logic                      outRegValid;
  decodedWordT               nextOut;
  logic                      regFree;
  logic                      absorbLow;
  logic                      loadOut;

  ////////////////////////////////////////////////////////////
  // flow control

  assign stageIsAm = stageValid && (stageWord.leaf == dumpAm);
  // empty or emptied this cycle
  assign regFree   = !outRegValid || outReady;
  // first chunk goes to lowChunk, no output slot needed
  assign absorbLow = stageIsAm && (state == waitLow);
  assign loadOut   = stageValid && !absorbLow && regFree;
  // stage is free or moves on this cycle
  assign inReady   = !stageValid || absorbLow || loadOut;

  // second chunk sits above the first
  always_comb begin
    nextOut = stageWord;
    if (stageIsAm) begin
      nextOut.payload = {stageWord.payload[`BD_AM_CHUNK_W-1:0], lowChunk};
    end
  end

  ////////////////////////////////////////////////////////////
  // control state

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stageValid  <= 1'b0;
      state       <= waitLow;
      outRegValid <= 1'b0;
    end else begin
      if (inReady) stageValid <= inValid;
      // other leaves leave the pairing state alone
      if (absorbLow) state <= waitHigh;
      else if (loadOut && stageIsAm) state <= waitLow;
      if (loadOut) outRegValid <= 1'b1;
      else if (outReady) outRegValid <= 1'b0;
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (inValid && inReady) stageWord <= inWord;
    if (absorbLow) lowChunk <= stageWord.payload[`BD_AM_CHUNK_W-1:0];
    if (loadOut) outReg <= nextOut;
  end

  assign outWord  = outReg;
  assign outValid = outRegValid;

endmodule

`default_nettype wire

/* logic/bdDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bdDecoder (
  input  logic                     clk,
  input  logic                     rstN,
  input  bdStreamPkg::rawWordT     inWord,
  input  logic                     inValid,
  output logic                     inReady,
  output bdStreamPkg::decodedWordT outWord,
  output logic                     outValid,
  input  logic                     outReady
);

  import bdStreamPkg::*;

  ////////////////////////////////////////////////////////////
  // decoder -> FIFO -> deserializer
  decodedWordT decWord;
  logic        decValid;
  logic        decReady;
  decodedWordT fifoWord;
  logic        fifoValid;
  logic        fifoReady;

  bdHornDecoder u_hornDecoder (
    .inWord   (inWord),
    .inValid  (inValid),
    .inReady  (inReady),
    .decWord  (decWord),
    .decValid (decValid),
    .decReady (decReady)
  );

  bdWordFifo u_wordFifo (
    .clk      (clk),
    .rstN     (rstN),
    .inWord   (decWord),
    .inValid  (decValid),
    .inReady  (decReady),
    .outWord  (fifoWord),
    .outValid (fifoValid),
    .outReady (fifoReady)
  );

  bdAmDeserializer u_amDeserializer (
    .clk      (clk),
    .rstN     (rstN),
    .inWord   (fifoWord),
    .inValid  (fifoValid),
    .inReady  (fifoReady),
    .outWord  (outWord),
    .outValid (outValid),
    .outReady (outReady)
  );

endmodule

`default_nettype wire

/* dv/bdDecoder_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module bdDecoder_assertions (
  input logic                     clk,
  input logic                     rstN,
  input logic                     inReady,
  input logic                     outValid,
  input logic                     outReady,
  input bdStreamPkg::decodedWordT outWord
);

  ////////////////////////////////////////////////////////////
  // output handshake

  // stalled word stays put until taken
  property pHoldUnderStall;
    @(posedge clk) disable iff (!rstN)
      (outValid && !outReady) |=> (outValid && $stable(outWord));
  endproperty

  aHoldUnderStall : assert property (pHoldUnderStall)
    else $error("outValid or outWord changed before the transfer");

  ////////////////////////////////////////////////////////////
  // reset behavior

  // nothing leaves during reset
  aIdleInReset : assert property (@(posedge clk) !rstN |-> !outValid)
    else $error("outValid high while rstN is low");

  // input side open right after reset
  aReadyAfterReset : assert property (@(posedge clk) $rose(rstN) |-> inReady)
    else $error("inReady low in the first cycle after reset");

endmodule

bind bdDecoder bdDecoder_assertions u_assertions (
  .clk      (clk),
  .rstN     (rstN),
  .inReady  (inReady),
  .outValid (outValid),
  .outReady (outReady),
  .outWord  (outWord)
);

`default_nettype wire

/* dv/bdDecoderTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bdDecoder_defines.svh"

module bdDecoderTb;

  import bdRoutePkg::*;
  import bdStreamPkg::*;

  localparam int RAND_WORDS      = 300;
  localparam int NUM_TESTS       = 5;
  localparam int MAX_FLIGHT      = `BD_FIFO_DEPTH + 2;
  // a full pipeline empties well within this
  localparam int DRAIN_CYCLES    = 4 * MAX_FLIGHT;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + RAND_WORDS * 50;

  ////////////////////////////////////////////////////////////
  // routing table, prefixes right-aligned, priority order
  localparam logic [6:0] ROUTE_PREFIX [NUM_LEAVES] = '{
    7'b0101000, 7'b0101001, 7'b0010101, 7'b0101110, 7'b0101111,
    7'b0101101, 7'b0001000, 7'b0001001, 7'b0000011, 7'b1011000,
    7'b1011001, 7'b0000001, 7'b0000000
  };
  localparam int ROUTE_LEN [NUM_LEAVES] = '{6, 6, 5, 6, 6, 6, 4, 4, 2, 7, 7, 2, 2};

  logic                      clk;
  logic                      rstN;
  rawWordT                   inWord;
  logic                      inValid;
  logic                      inReady;
  decodedWordT               outWord;
  logic                      outValid;
  logic                      outReady;
  // reference model state
  decodedWordT               expQ [$];
  logic [`BD_AM_CHUNK_W-1:0] amLow;
  logic                      amPending;
  logic [31:0]               lcgState;
  logic                      stallOn;
  logic                      failReported;
  logic                      runPassed;

  bdDecoder u_dut (
    .clk      (clk),
    .rstN     (rstN),
    .inWord   (inWord),
    .inValid  (inValid),
    .inReady  (inReady),
    .outWord  (outWord),
    .outValid (outValid),
    .outReady (outReady)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // random source and word building

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  // upper halves only, low lcg bits are weak
  function automatic logic [`BD_DATA_W-1:0] randBody();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = nextRand();
    hi = nextRand();
    return {hi[17:16], lo[31:16], hi[31:16]};
  endfunction

  // route prefix on top of a body
  function automatic rawWordT buildWord(int route, logic [`BD_DATA_W-1:0] body);
    rawWordT w;
    w.data = (body & ({`BD_DATA_W{1'b1}} >> ROUTE_LEN[route]))
           | (`BD_DATA_W'(ROUTE_PREFIX[route]) << (`BD_DATA_W - ROUTE_LEN[route]));
    return w;
  endfunction

  // first matching prefix wins, route bits dropped
  function automatic decodedWordT expectDecode(rawWordT w);
    decodedWordT           d;
    logic [`BD_DATA_W-1:0] body;
    logic                  found;
    d.leaf = invalid;
    body   = w.data;
    found  = 1'b0;
    for (int i = 0; i < NUM_LEAVES; i++) begin
      if (!found && (w.data >> (`BD_DATA_W - ROUTE_LEN[i])) == `BD_DATA_W'(ROUTE_PREFIX[i])) begin
        found  = 1'b1;
        d.leaf = leafT'(4'(i));
        body   = w.data & ({`BD_DATA_W{1'b1}} >> ROUTE_LEN[i]);
      end
    end
    d.payload = `BD_PAYLOAD_W'(body[`BD_SINGLE_PAYLOAD_W-1:0]);
    return d;
  endfunction

  // AM chunks pair up, other leaves go straight to the queue
  task automatic modelAccept(rawWordT w);
    decodedWordT d;
    d = expectDecode(w);
    if (d.leaf != dumpAm) begin
      expQ.push_back(d);
    end else if (!amPending) begin
      amLow     = d.payload[`BD_AM_CHUNK_W-1:0];
      amPending = 1'b1;
    end else begin
      d.payload = {d.payload[`BD_AM_CHUNK_W-1:0], amLow};
      expQ.push_back(d);
      amPending = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checks

  task automatic failRun();
    failReported = 1'b1;
    $display("TB FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic checkLeaf(string sig, leafT exp, leafT act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %s, got %s", $time, sig, exp.name(), act.name());
      failRun();
    end
  endtask

  task automatic checkPayload(string sig, logic [`BD_PAYLOAD_W-1:0] exp,
                              logic [`BD_PAYLOAD_W-1:0] act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, sig, exp, act);
      failRun();
    end
  endtask

  task automatic checkIdle();
    if (outValid && expQ.size() == 0) begin
      $display("Error at %0t: outValid is high but no output word is expected", $time);
      failRun();
    end
  endtask

  // output monitor, one compare per transfer
  always @(posedge clk) begin : outputMonitor
    decodedWordT expWord;
    if (rstN) begin
      checkIdle();
      if (outValid && outReady) begin
        expWord = expQ.pop_front();
        checkLeaf("outWord.leaf", expWord.leaf, outWord.leaf);
        checkPayload("outWord.payload", expWord.payload, outWord.payload);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // drivers, each starts and ends just after a falling edge

  task automatic drawStall();
    logic [31:0] r;
    if (stallOn) begin
      r = nextRand();
      // ready three cycles out of four
      outReady = r[31:30] != 2'b00;
    end
  endtask

  task automatic holdUntilAccepted(rawWordT w);
    @(posedge clk);
    while (!inReady) begin
      @(negedge clk);
      drawStall();
      @(posedge clk);
    end
    modelAccept(w);
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic sendWord(rawWordT w);
    inWord  = w;
    inValid = 1'b1;
    drawStall();
    holdUntilAccepted(w);
  endtask

  // output open until the queue empties or the pipeline is surely empty
  task automatic drain();
    int waited;
    stallOn  = 1'b0;
    outReady = 1'b1;
    waited   = 0;
    while (expQ.size() != 0 && waited < DRAIN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests

  // dumpAm sends two words, so they pair
  task automatic testEveryLeaf();
    for (int r = 0; r < NUM_LEAVES; r++) begin
      sendWord(buildWord(r, '1));
      sendWord(buildWord(r, randBody()));
    end
    drain();
  endtask

  // every 7-bit prefix, no-hit words decode as invalid in the model
  task automatic testPrefixSweep();
    rawWordT               w;
    logic [`BD_DATA_W-1:0] body;
    for (int p = 0; p < 128; p++) begin
      body   = randBody();
      w.data = {7'(p), body[26:0]};
      sendWord(w);
    end
    drain();
  endtask

  // other leaves overtake the waiting chunk
  task automatic testAmPairing();
    sendWord(buildWord(int'(dumpAm), randBody()));
    sendWord(buildWord(int'(nrni), randBody()));
    sendWord(buildWord(int'(roTat), randBody()));
    sendWord(buildWord(int'(dumpAm), randBody()));
    // back-to-back pair
    sendWord(buildWord(int'(dumpAm), randBody()));
    sendWord(buildWord(int'(dumpAm), randBody()));
    drain();
  endtask

  task automatic testBackPressure();
    rawWordT w;
    int      accepted;
    logic    stalled;
    outReady = 1'b0;
    accepted = 0;
    stalled  = 1'b0;
    while (!stalled) begin
      // non-AM leaves only
      w       = buildWord(1 + (accepted % 12), randBody());
      inWord  = w;
      inValid = 1'b1;
      @(posedge clk);
      if (inReady) begin
        modelAccept(w);
        accepted++;
        @(negedge clk);
        if (accepted > MAX_FLIGHT) begin
          $display("Error at %0t: inReady still high after %0d words", $time, accepted);
          failRun();
        end
      end else begin
        stalled = 1'b1;
      end
    end
    // pipeline full, input stays closed
    repeat (10) begin
      @(negedge clk);
      @(posedge clk);
      if (inReady) begin
        $display("Error at %0t: inReady rose while the output was stalled", $time);
        failRun();
      end
    end
    @(negedge clk);
    outReady = 1'b1;
    holdUntilAccepted(w);
    drain();
  endtask

  task automatic testRandomStream();
    logic [31:0] r;
    stallOn = 1'b1;
    for (int n = 0; n < RAND_WORDS; n++) begin
      r = nextRand();
      sendWord(buildWord(int'(r[31:16] % 16'd13), randBody()));
    end
    // close a lone chunk
    if (amPending) begin
      sendWord(buildWord(int'(dumpAm), randBody()));
    end
    drain();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    clk          = 1'b0;
    rstN         = 1'b0;
    inWord       = '0;
    inValid      = 1'b0;
    outReady     = 1'b1;
    stallOn      = 1'b0;
    amPending    = 1'b0;
    amLow        = '0;
    failReported = 1'b0;
    runPassed    = 1'b0;
    lcgState     = 32'd76286;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    testEveryLeaf();
    testPrefixSweep();
    testAmPairing();
    testBackPressure();
    testRandomStream();
    repeat (4) @(negedge clk);
    if (expQ.size() != 0) begin
      $display("Error at %0t: %0d expected words never came out", $time, expQ.size());
      failRun();
    end else begin
      runPassed = 1'b1;
      $display("TB PASSED");
      $finish;
    end
  end

  // hang guard
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout at %0t: no result after %0d cycles, the DUT looks hung",
             $time, WATCHDOG_CYCLES);
    failRun();
  end

  // run stopped by an assertion
  final begin
    if (!runPassed && !failReported) begin
      $display("TB FAILED");
    end
  end

endmodule

`default_nettype wire

/* bdDecoder.f */
+incdir+include
logic/bdRoutePkg.sv
logic/bdStreamPkg.sv
logic/bdHornDecoder.sv
logic/bdWordFifo.sv
logic/bdAmDeserializer.sv
logic/bdDecoder.sv
dv/bdDecoder_assertions.sv
dv/bdDecoderTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# build and run the bdDecoder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  -f bdDecoder.f \
  --top-module bdDecoderTb

# result is taken from the log, not from the exit status
./obj_dir/VbdDecoderTb 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"
